/* compile.f */
+incdir+include
hw/game_pkg.sv
hw/button_debounce.sv
hw/round_timer.sv
hw/round_fsm.sv
hw/bcd_convert.sv
hw/seg_scan.sv
hw/game_hud_top.sv
tests/tb_game_hud.sv

/* include/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

localparam logic [31:0] LFSR_SEED = 32'h3169a415;

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] value);
    if (value[0]) begin
        return (value >> 1) ^ 32'h8020_0003;
    end
    return value >> 1;
endfunction

// segments g..a, active high, indexed by hex digit
localparam logic [6:0] SEG_REF [16] = '{
    7'b011_1111, 7'b000_0110, 7'b101_1011, 7'b100_1111,
    7'b110_0110, 7'b110_1101, 7'b111_1101, 7'b000_0111,
    7'b111_1111, 7'b110_1111, 7'b111_0111, 7'b111_1100,
    7'b011_1001, 7'b101_1110, 7'b111_1001, 7'b111_0001
};

`endif

/* tests/tb_game_hud.sv */
module tb_game_hud;

    `include "tb_util.svh"

    localparam logic [19:0] DEBOUNCE_CYCLES  = 20'd4;
    localparam logic [31:0] TICK_CYCLES      = 32'd40;
    localparam logic [7:0]  ROUND_SECONDS    = 8'd12;
    localparam logic [9:0]  POINTS_PER_ORDER = 10'd250;
    localparam logic [31:0] SCAN_CYCLES      = 32'd3;
    // round length plus button traffic and scans, times two
    localparam int WATCHDOG_CYCLES =
        2 * (ROUND_SECONDS * TICK_CYCLES + 64 * SCAN_CYCLES + 400);

    logic                   clk_in, reset_in, btn_start, btn_score, sw_pause;
    logic [6:0]             cat;
    logic [7:0]             an;
    game_pkg::round_state_e round_state;
    logic [7:0]             time_left;
    logic [9:0]             points;
    logic [31:0]            lfsr;
    logic [20:0]            hist0, hist1, hist2;  // status seen on the last three negedges
    logic [7:0]             digits_seen;
    int                     errors, test_errors, shown, settled, lit, exp_points, n;
    logic [7:0]             held;

    game_hud_top #(
        .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
        .TICK_CYCLES      (TICK_CYCLES),
        .ROUND_SECONDS    (ROUND_SECONDS),
        .POINTS_PER_ORDER (POINTS_PER_ORDER),
        .SCAN_CYCLES      (SCAN_CYCLES)
    ) dut (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .btn_start   (btn_start),
        .btn_score   (btn_score),
        .sw_pause    (sw_pause),
        .cat         (cat),
        .an          (an),
        .round_state (round_state),
        .time_left   (time_left),
        .points      (points)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic flag_wrong(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic flag_failure(input string msg);
        errors++;
        $display("failure at time %0t: %s", $time, msg);
    endtask

    function automatic int take_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    // time in digits 0 to 2 and points in 4 to 6
    function automatic logic [6:0] expected_cat(input int idx, input logic [2:0] st,
                                                input logic [7:0] tl, input logic [9:0] pt);
        int value;
        case (idx)
            0, 1, 2: value = (int'(tl) / (10 ** idx)) % 10;
            3:       return 7'h7f;
            4, 5, 6: value = (int'(pt) / (10 ** (idx - 4))) % 10;
            default: value = st;
        endcase
        return ~SEG_REF[value];
    endfunction

    task automatic drive_input(input int which, input logic value);
        @(posedge clk_in);
        case (which)
            0:       btn_start <= value;
            1:       btn_score <= value;
            default: sw_pause  <= value;
        endcase
    endtask

    task automatic pulse_input(input int which, input int cycles);
        drive_input(which, 1'b1);
        repeat (cycles - 1) @(posedge clk_in);
        drive_input(which, 1'b0);
        repeat (4 + take_bits(4)) @(posedge clk_in);  // random gap
    endtask

    task automatic wait_for_state(input game_pkg::round_state_e target, input int limit);
        int count;
        count = 0;
        while (round_state != target && count < limit) begin
            @(negedge clk_in);
            count++;
        end
        if (round_state != target) begin
            flag_failure($sformatf("round state never reached %s", target.name()));
        end
    endtask

    task automatic wait_time_change(input int limit, output int cycles);
        logic [7:0] start_value;
        start_value = time_left;
        cycles = 0;
        while (time_left == start_value && cycles < limit) begin
            @(negedge clk_in);
            cycles++;
        end
        if (time_left == start_value) begin
            flag_failure("time_left stopped counting down");
        end
    endtask

    task automatic wait_points(input int expected, input int limit);
        int count;
        count = 0;
        while (points != expected && count < limit) begin
            @(negedge clk_in);
            count++;
        end
        assert (points == expected)
            else flag_wrong($sformatf("points %0d, expected %0d", points, expected));
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == test_errors) ? "ok" : "has errors");
        test_errors = errors;
    endtask

    //////////////////////////////
    // continuous checks
    //////////////////////////////

    a_time_step: assert property (@(posedge clk_in) disable iff (reset_in)
        (round_state == game_pkg::PLAY && $past(round_state) == game_pkg::PLAY)
        |-> (time_left == $past(time_left) || time_left == $past(time_left) - 8'd1))
        else flag_wrong("time_left rose or skipped a second in PLAY");

    a_pause_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        (round_state == game_pkg::PAUSE) |=> $stable(time_left))
        else flag_wrong("time_left moved while paused");

    a_points_cap: assert property (@(posedge clk_in) disable iff (reset_in)
        points <= game_pkg::POINTS_MAX)
        else flag_wrong("points above the cap");

    // cat trails status by two register stages
    always @(negedge clk_in) begin
        hist2 = hist1;
        hist1 = hist0;
        hist0 = {round_state, time_left, points};
        if (reset_in) begin
            settled = 0;
        end else begin
            if (settled < 3) settled++;
            lit = 0;
            for (int i = 0; i < 8; i++) begin
                if (!an[i]) lit = i;
            end
            assert (an != 8'hff && (~an & (~an - 8'd1)) == 8'd0)
                else flag_wrong($sformatf("an %b is not one-hot low", an));
            if (settled == 3 && hist0 == hist1 && hist1 == hist2) begin
                shown++;
                digits_seen[lit] = 1'b1;
                assert (cat == expected_cat(lit, round_state, time_left, points))
                    else flag_wrong($sformatf("digit %0d cat %b", lit, cat));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        lfsr        = LFSR_SEED;
        errors      = 0;
        test_errors = 0;
        shown       = 0;
        settled     = 0;
        digits_seen = '0;
        btn_start   = 1'b0;
        btn_score   = 1'b0;
        sw_pause    = 1'b0;
        reset_in    = 1'b1;
        repeat (10) @(posedge clk_in);
        reset_in <= 1'b0;
        @(negedge clk_in);

        assert (round_state == game_pkg::WELCOME) else flag_wrong("state after reset");
        assert (time_left == ROUND_SECONDS) else flag_wrong("time_left after reset");
        assert (points == 10'd0) else flag_wrong("points after reset");
        assert (an == 8'b1111_1110) else flag_wrong("an after reset");
        report_test(1, "reset values");

        repeat (6) begin
            pulse_input(0, 1 + take_bits(2) % 3);  // short glitch
        end
        assert (round_state == game_pkg::WELCOME) else flag_wrong("glitch moved the round");
        pulse_input(1, 8);  // score before the round
        assert (points == 10'd0) else flag_wrong("score counted in welcome");
        drive_input(0, 1'b1);
        wait_for_state(game_pkg::START, 30);
        wait_for_state(game_pkg::PLAY, 4);
        repeat (7) @(posedge clk_in);
        drive_input(0, 1'b0);
        report_test(2, "glitch filter and round start");

        wait_time_change(2 * TICK_CYCLES, n);
        wait_time_change(2 * TICK_CYCLES, n);
        assert (n == TICK_CYCLES) else flag_wrong($sformatf("second lasted %0d cycles", n));
        drive_input(2, 1'b1);
        wait_for_state(game_pkg::PAUSE, 30);
        held = time_left;
        pulse_input(1, 8);  // score while paused
        repeat (TICK_CYCLES) @(negedge clk_in);
        assert (time_left == held) else flag_wrong("time_left moved in pause");
        assert (points == 10'd0) else flag_wrong("score counted in pause");
        drive_input(2, 1'b0);
        wait_for_state(game_pkg::PLAY, 30);
        report_test(3, "countdown and pause");

        repeat (3) begin
            pulse_input(1, 1 + take_bits(2) % 3);  // short glitch in play
        end
        assert (points == 10'd0) else flag_wrong("glitch changed points");
        exp_points = 0;
        repeat (4) begin
            exp_points = exp_points + POINTS_PER_ORDER;
            if (exp_points > game_pkg::POINTS_MAX) exp_points = game_pkg::POINTS_MAX;
            pulse_input(1, 8);
            wait_points(exp_points, 30);
        end
        report_test(4, "score presses");

        wait_for_state(game_pkg::FINISH, ROUND_SECONDS * TICK_CYCLES + 100);
        assert (time_left == 8'd0) else flag_wrong("finish with time left");
        report_test(5, "round end");

        drive_input(0, 1'b1);
        wait_for_state(game_pkg::WELCOME, 30);
        @(negedge clk_in);  // reload lands one cycle into welcome
        assert (time_left == ROUND_SECONDS) else flag_wrong("timer not reloaded in welcome");
        repeat (7) @(posedge clk_in);
        drive_input(0, 1'b0);
        repeat (8) @(posedge clk_in);
        drive_input(0, 1'b1);
        wait_for_state(game_pkg::START, 30);
        wait_for_state(game_pkg::PLAY, 4);
        assert (time_left == ROUND_SECONDS) else flag_wrong("timer not reloaded");
        assert (points == 10'd0) else flag_wrong("points not cleared");
        repeat (7) @(posedge clk_in);
        drive_input(0, 1'b0);
        repeat (16 * SCAN_CYCLES) @(negedge clk_in);
        assert (digits_seen == 8'hff) else flag_failure("not every digit was checked");
        report_test(6, "return to welcome and display");

        $display("tests 6, display checks %0d, errors %0d", shown, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hw/game_hud_top.sv */
module game_hud_top #(
    parameter logic [19:0] DEBOUNCE_CYCLES  = 20'd1_000_000,
    parameter logic [31:0] TICK_CYCLES      = 32'd100_000_000,
    parameter logic [7:0]  ROUND_SECONDS    = 8'd90,
    parameter logic [9:0]  POINTS_PER_ORDER = 10'd20,
    parameter logic [31:0] SCAN_CYCLES      = 32'd100_000
) (
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   btn_start,
    input  logic                   btn_score,
    input  logic                   sw_pause,
    output logic [6:0]             cat,
    output logic [7:0]             an,
    output game_pkg::round_state_e round_state,  // board leds
    output logic [7:0]             time_left,
    output logic [9:0]             points
);

    game_pkg::buttons_t    buttons;
    game_pkg::hud_status_t status;
    game_pkg::hud_digits_t digits;

    //////////////////////////////
    // debounce
    //////////////////////////////

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_start (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .noisy    (btn_start),
        .level    (),
        .press    (buttons.start_press)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_score (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .noisy    (btn_score),
        .level    (),
        .press    (buttons.score_press)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_pause (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .noisy    (sw_pause),
        .level    (buttons.pause_level),  // switch, level only
        .press    ()
    );

    //////////////////////////////
    // round, decimal, display
    //////////////////////////////

    round_fsm #(
        .TICK_CYCLES      (TICK_CYCLES),
        .ROUND_SECONDS    (ROUND_SECONDS),
        .POINTS_PER_ORDER (POINTS_PER_ORDER)
    ) round (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .buttons  (buttons),
        .status   (status)
    );

    bcd_convert bcd (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .status   (status),
        .digits   (digits)
    );

    seg_scan #(.SCAN_CYCLES(SCAN_CYCLES)) scan (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .digits   (digits),
        .cat      (cat),
        .an       (an)
    );

    assign round_state = status.state;
    assign time_left   = status.time_left;
    assign points      = status.points;

endmodule

/* hw/seg_scan.sv */
module seg_scan #(
    parameter logic [31:0] SCAN_CYCLES = 32'd100_000
) (
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  game_pkg::hud_digits_t digits,
    output logic [6:0]            cat,  // active low, g..a
    output logic [7:0]            an    // active low
);

    logic [31:0] scan_count;
    logic        scan_done;
    logic [7:0]  an_next;
    logic [3:0]  nibble;
    logic        blank;
    logic [6:0]  seg;  // active high

    assign scan_done = (scan_count == SCAN_CYCLES - 32'd1);

    always_comb begin
        if (reset_in) begin
            an_next = 8'b1111_1110;
        end else if (scan_done) begin
            an_next = {an[6:0], an[7]};  // rotate to next digit
        end else begin
            an_next = an;
        end
    end

    // pick the nibble for the digit about to be lit
    always_comb begin
        blank = 1'b0;
        case (an_next)
            8'b1111_1110: nibble = digits.time_bcd[0];
            8'b1111_1101: nibble = digits.time_bcd[1];
            8'b1111_1011: nibble = digits.time_bcd[2];
            8'b1110_1111: nibble = digits.points_bcd[0];
            8'b1101_1111: nibble = digits.points_bcd[1];
            8'b1011_1111: nibble = digits.points_bcd[2];
            8'b0111_1111: nibble = {1'b0, digits.state};
            default: begin  // digit 3 gap
                nibble = 4'h0;
                blank  = 1'b1;
            end
        endcase
    end

    //////////////////////////////
    // hex to segments
    //////////////////////////////

    always_comb begin
        case (nibble)
            4'h0: seg = 7'b011_1111;
            4'h1: seg = 7'b000_0110;
            4'h2: seg = 7'b101_1011;
            4'h3: seg = 7'b100_1111;
            4'h4: seg = 7'b110_0110;
            4'h5: seg = 7'b110_1101;
            4'h6: seg = 7'b111_1101;
            4'h7: seg = 7'b000_0111;
            4'h8: seg = 7'b111_1111;
            4'h9: seg = 7'b110_1111;
            4'ha: seg = 7'b111_0111;
            4'hb: seg = 7'b111_1100;
            4'hc: seg = 7'b011_1001;
            4'hd: seg = 7'b101_1110;
            4'he: seg = 7'b111_1001;
            default: seg = 7'b111_0001;  // f
        endcase
    end

    always_ff @(posedge clk_in) begin
        an  <= an_next;
        cat <= blank ? 7'b111_1111 : ~seg;  // same edge as an
        if (reset_in || scan_done) begin
            scan_count <= '0;
        end else begin
            scan_count <= scan_count + 32'd1;
        end
    end

endmodule

/* hw/bcd_convert.sv */
module bcd_convert (
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  game_pkg::hud_status_t status,
    output game_pkg::hud_digits_t digits
);

    logic [11:0] time_bcd;
    logic [11:0] points_bcd;

    // shift-and-add-3, {hundreds, tens, ones}
    // inputs above 999 do not occur here
    function automatic logic [11:0] to_bcd3(input logic [9:0] bin);
        logic [21:0] work;
        work = {12'd0, bin};
        for (int i = 0; i < 10; i++) begin
            if (work[13:10] > 4'd4) begin
                work[13:10] = work[13:10] + 4'd3;
            end
            if (work[17:14] > 4'd4) begin
                work[17:14] = work[17:14] + 4'd3;
            end
            if (work[21:18] > 4'd4) begin
                work[21:18] = work[21:18] + 4'd3;
            end
            work = work << 1;
        end
        return work[21:10];
    endfunction

    assign time_bcd   = to_bcd3({2'b00, status.time_left});
    assign points_bcd = to_bcd3(status.points);

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        digits.time_bcd   <= time_bcd;
        digits.points_bcd <= points_bcd;
        if (reset_in) begin
            digits.state <= game_pkg::WELCOME;
        end else begin
            digits.state <= status.state;
        end
    end

endmodule

/* hw/round_fsm.sv */
module round_fsm #(
    parameter logic [31:0] TICK_CYCLES      = 32'd100_000_000,
    parameter logic [7:0]  ROUND_SECONDS    = 8'd90,
    parameter logic [9:0]  POINTS_PER_ORDER = 10'd20
) (
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  game_pkg::buttons_t    buttons,
    output game_pkg::hud_status_t status
);

    game_pkg::round_state_e state;
    logic [9:0]  points;
    logic [10:0] points_sum;  // one spare bit, 999 + order can pass 1023
    logic [7:0]  time_left;
    logic        go;
    logic        restart;

    //////////////////////////////
    // timer control
    //////////////////////////////

    always_comb begin
        go      = 1'b0;
        restart = 1'b0;
        case (state)
            game_pkg::PLAY:                  go = 1'b1;
            game_pkg::WELCOME, game_pkg::START: restart = 1'b1;
            default: ;  // pause and finish freeze the clock
        endcase
    end

    round_timer #(
        .TICK_CYCLES   (TICK_CYCLES),
        .ROUND_SECONDS (ROUND_SECONDS)
    ) timer (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .go        (go),
        .restart   (restart),
        .time_left (time_left)
    );

    //////////////////////////////
    // round state and score
    //////////////////////////////

    assign points_sum = {1'b0, points} + {1'b0, POINTS_PER_ORDER};

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            state  <= game_pkg::WELCOME;
            points <= '0;
        end else begin
            case (state)
                game_pkg::WELCOME: if (buttons.start_press) state <= game_pkg::START;
                game_pkg::START: begin
                    state  <= game_pkg::PLAY;
                    points <= '0;
                end
                game_pkg::PLAY: begin
                    if (time_left == 8'd0) begin
                        state <= game_pkg::FINISH;
                    end else if (buttons.pause_level) begin
                        state <= game_pkg::PAUSE;
                    end
                    if (buttons.score_press) begin
                        if (points_sum > {1'b0, game_pkg::POINTS_MAX}) begin
                            points <= game_pkg::POINTS_MAX;
                        end else begin
                            points <= points_sum[9:0];
                        end
                    end
                end
                game_pkg::PAUSE:  if (!buttons.pause_level) state <= game_pkg::PLAY;
                game_pkg::FINISH: if (buttons.start_press) state <= game_pkg::WELCOME;
                default: state <= game_pkg::WELCOME;
            endcase
        end
    end

    assign status = '{state, time_left, points};

endmodule

/* hw/round_timer.sv */
module round_timer #(
    parameter logic [31:0] TICK_CYCLES   = 32'd100_000_000,
    parameter logic [7:0]  ROUND_SECONDS = 8'd90
) (
    input  logic       clk_in,
    input  logic       reset_in,
    input  logic       go,
    input  logic       restart,
    output logic [7:0] time_left
);

    logic [31:0] prescale;  // cycles into the current second
    logic        tick;

    assign tick = (prescale == TICK_CYCLES - 32'd1);

    always_ff @(posedge clk_in) begin
        if (reset_in || restart) begin
            prescale  <= '0;
            time_left <= ROUND_SECONDS;
        end else if (go && time_left != 8'd0) begin
            if (tick) begin
                prescale  <= '0;
                time_left <= time_left - 8'd1;
            end else begin
                prescale <= prescale + 32'd1;
            end
        end
        // go low: prescaler and seconds both hold
    end

endmodule

/* hw/button_debounce.sv */
module button_debounce #(
    parameter logic [19:0] DEBOUNCE_CYCLES = 20'd1_000_000
) (
    input  logic clk_in,
    input  logic reset_in,
    input  logic noisy,
    output logic level,
    output logic press
);

    logic [1:0]  sync;     // two-flop synchronizer
    logic [19:0] count;    // cycles the input has differed from level
    logic        level_d;  // edge register

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            sync    <= {noisy, noisy};
            level   <= noisy;  // start at the current level, no pulse out of reset
            level_d <= noisy;
            count   <= '0;
        end else begin
            sync    <= {sync[0], noisy};
            level_d <= level;
            if (sync[1] == level) begin
                count <= '0;  // bounced back
            end else if (count == DEBOUNCE_CYCLES - 20'd1) begin
                level <= sync[1];
                count <= '0;
            end else begin
                count <= count + 20'd1;
            end
        end
    end

    assign press = level & ~level_d;  // rising edge of the clean level

endmodule

/* hw/game_pkg.sv */
package game_pkg;

    //////////////////////////////
    // round states
    //////////////////////////////

    typedef enum logic [2:0] {
        WELCOME = 3'd0,
        START   = 3'd1,
        PLAY    = 3'd2,
        PAUSE   = 3'd3,
        FINISH  = 3'd4
    } round_state_e;

    localparam logic [9:0] POINTS_MAX = 10'd999;  // score display has three digits

    //////////////////////////////
    // stage payloads
    //////////////////////////////

    // debounce -> round control
    typedef struct packed {
        logic start_press;  // one-cycle pulse
        logic score_press;  // one-cycle pulse
        logic pause_level;
    } buttons_t;

    // round control -> decimal
    typedef struct packed {
        round_state_e state;
        logic [7:0]   time_left;  // seconds
        logic [9:0]   points;
    } hud_status_t;

    // decimal -> display, index 0 is the ones digit
    typedef struct packed {
        logic [2:0]       state;
        logic [2:0][3:0]  time_bcd;
        logic [2:0][3:0]  points_bcd;
    } hud_digits_t;

endpackage
